// ==== verilog/sync_fifo_defs.svh ====
// sizing and build choices shared by the FIFO subsystem and its memory

`ifndef SYNC_FIFO_DEFS_SVH
`define SYNC_FIFO_DEFS_SVH

//############################################################
// word and array geometry
//############################################################
`define FIFO_DW       32                    // bits per stored word
`define FIFO_DEPTH    16                    // words in the array
`define FIFO_AW       $clog2(`FIFO_DEPTH)   // address bits, derived

//############################################################
// controller options
//############################################################
`define FIFO_PROGFULL 12   // almost-full level, compared as "at least"
`define FIFO_REG      1    // 1 = memory output register, adds a read stage

`endif

// ==== verilog/sync_fifo_pkg.sv ====
// shared vector types, memory port structs and self-test states for the FIFO subsystem

`include "sync_fifo_defs.svh"

package sync_fifo_pkg;

   // widths with a meaning
   typedef logic [`FIFO_DW-1:0] data_t;   // one FIFO word
   typedef logic [`FIFO_AW-1:0] addr_t;   // memory address
   typedef logic [`FIFO_AW:0]   ptr_t;    // pointer, msb is the wrap flag
   typedef logic [`FIFO_AW:0]   count_t;  // stored words, reaches DEPTH

   // one write into the array
   typedef struct packed {
      logic  en;     // write strobe
      addr_t addr;   // target word
      data_t data;   // full word, no mask
   } mem_wr_s;

   // one read request, data returns after the read latency
   typedef struct packed {
      logic  en;     // read strobe
      addr_t addr;   // source word
   } mem_rd_s;

   // self-test sequencer
   typedef enum logic [2:0] {
      idle,          // waiting for start
      write_pat,     // write pattern A everywhere
      read_pat,      // read back and check A
      write_inv,     // write inverse of A
      read_inv,      // read back and check inverse
      drain,         // let in-flight reads land
      finish         // one cycle done pulse
   } bist_state_t;

endpackage

// ==== verilog/mem_dual_port.sv ====
// dual-port word memory with synchronous read, optional output stage and self-test port mux
`timescale 1ns/1ps
`include "sync_fifo_defs.svh"

module mem_dual_port #(
   parameter int REG = 1                        // 1 = extra output register
) (
   input  logic                   clk,          // clock
   input  sync_fifo_pkg::mem_wr_s wr,           // functional write
   input  sync_fifo_pkg::mem_rd_s rd,           // functional read
   input  logic                   bist_en,      // test port owns the memory
   input  sync_fifo_pkg::mem_wr_s bist_wr,      // test write
   input  sync_fifo_pkg::mem_rd_s bist_rd,      // test read
   output sync_fifo_pkg::data_t   rd_data       // read word
);

   import sync_fifo_pkg::*;

   mem_wr_s wr_sel;                      // write request after the mux
   mem_rd_s rd_sel;                      // read request after the mux
   data_t   mem_array [`FIFO_DEPTH];     // storage, no reset like a real RAM
   data_t   rd_q;                        // first read stage

   //############################################################
   // port select
   //############################################################
   // test port takes over both ports while bist_en is high
   assign wr_sel = bist_en ? bist_wr : wr;
   assign rd_sel = bist_en ? bist_rd : rd;

   //############################################################
   // array and read stage
   //############################################################
   always_ff @(posedge clk)
   begin
      if (wr_sel.en)
         mem_array[wr_sel.addr] <= wr_sel.data;   // full word write
   end

   // read before write on an address collision
   always_ff @(posedge clk)
   begin
      if (rd_sel.en)
         rd_q <= mem_array[rd_sel.addr];
   end

   //############################################################
   // optional output register
   //############################################################
   generate
      if (REG != 0)
      begin : g_out_reg
         logic  rd_en_q;   // a read landed in rd_q last edge
         data_t out_q;     // second stage

         always_ff @(posedge clk)
         begin
            rd_en_q <= rd_sel.en;
         end

         // load only behind a read, so the word stays put otherwise
         always_ff @(posedge clk)
         begin
            if (rd_en_q)
               out_q <= rd_q;
         end

         assign rd_data = out_q;
      end
      else
      begin : g_no_reg
         assign rd_data = rd_q;   // one cycle read latency
      end
   endgenerate

endmodule

// ==== verilog/fifo_sync.sv ====
// synchronous FIFO controller with wrap-flagged pointers, level flags and its dual-port memory
`timescale 1ns/1ps
`include "sync_fifo_defs.svh"

module fifo_sync #(
   parameter int REG      = 1,                  // memory output register present
   parameter int PROGFULL = 12                  // almost-full level
) (
   input  logic                   clk,          // clock
   input  logic                   nreset,       // async reset, active low
   input  logic                   clear,        // sync clear, wins over write/read
   input  logic                   write,        // write strobe
   input  sync_fifo_pkg::data_t   din,          // write word
   input  logic                   read,         // read strobe
   input  logic                   bist_en,      // self-test owns the memory
   input  logic                   bist_done,    // self-test finished, drop contents
   input  sync_fifo_pkg::mem_wr_s bist_wr,      // test write request
   input  sync_fifo_pkg::mem_rd_s bist_rd,      // test read request
   output sync_fifo_pkg::data_t   dout,         // read word
   output logic                   full,         // no room
   output logic                   empty,        // nothing to read
   output sync_fifo_pkg::count_t  count,        // stored words
   output logic                   progfull,     // count at or above PROGFULL
   output sync_fifo_pkg::data_t   mem_data      // raw memory read data
);

   import sync_fifo_pkg::*;

   localparam int aw = `FIFO_AW;    // address part of a pointer

   ptr_t    wr_ptr;       // next slot to write
   ptr_t    rd_ptr;       // next slot to read
   logic    ptr_match;    // same address, wrap bits decide full/empty
   logic    ptr_full;
   logic    ptr_empty;
   logic    empty_now;    // unregistered empty, forced during test
   logic    empty_reg;    // empty delayed to match the output register
   logic    fifo_write;   // accepted write
   logic    fifo_read;    // accepted read
   mem_wr_s mem_wr;
   mem_rd_s mem_rd;
   data_t   rd_data;

   //############################################################
   // flags
   //############################################################
   assign ptr_match = (wr_ptr[aw-1:0] == rd_ptr[aw-1:0]);
   assign ptr_full  = ptr_match & (wr_ptr[aw] != rd_ptr[aw]);   // writer lapped
   assign ptr_empty = ptr_match & (wr_ptr[aw] == rd_ptr[aw]);

   // both flags read high while self-test has the memory
   assign full      = ptr_full | bist_en;
   assign empty_now = ptr_empty | bist_en;

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         empty_reg <= 1'b1;
      else
         empty_reg <= empty_now;
   end

   assign empty = (REG != 0) ? empty_reg : empty_now;

   // pointer difference, wrap flag makes DEPTH reachable
   assign count    = wr_ptr - rd_ptr;
   assign progfull = (count >= count_t'(PROGFULL));

   // a lagging registered empty must not let a read through
   assign fifo_write = write & ~full;
   assign fifo_read  = read & ~(empty | empty_now);

   //############################################################
   // pointers
   //############################################################
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end
      else if (clear || bist_done)   // memory no longer holds FIFO data after test
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end
      else
      begin
         if (fifo_write)
            wr_ptr <= wr_ptr + 1'b1;
         if (fifo_read)
            rd_ptr <= rd_ptr + 1'b1;   // both moving keeps count steady
      end
   end

   //############################################################
   // memory
   //############################################################
   assign mem_wr = '{en: fifo_write, addr: wr_ptr[aw-1:0], data: din};
   assign mem_rd = '{en: fifo_read, addr: rd_ptr[aw-1:0]};

   mem_dual_port #(
      .REG     (REG)
   ) mem0 (
      .clk     (clk),
      .wr      (mem_wr),
      .rd      (mem_rd),
      .bist_en (bist_en),
      .bist_wr (bist_wr),
      .bist_rd (bist_rd),
      .rd_data (rd_data)
   );

   assign dout     = rd_data;   // word lands 1 or 2 edges after the read
   assign mem_data = rd_data;   // same word, seen by the test engine

endmodule

// ==== verilog/mem_bist.sv ====
// march self-test engine writing and checking address patterns through the memory test port
`timescale 1ns/1ps
`include "sync_fifo_defs.svh"

module mem_bist #(
   parameter int REG = 1                        // memory output register present
) (
   input  logic                   clk,          // clock
   input  logic                   nreset,       // async reset, active low
   input  logic                   start,        // start pulse, ignored when busy
   input  sync_fifo_pkg::data_t   rd_data,      // memory read data
   output logic                   bist_en,      // take over the memory
   output sync_fifo_pkg::mem_wr_s bist_wr,      // test write
   output sync_fifo_pkg::mem_rd_s bist_rd,      // test read
   output logic                   busy,         // passes running
   output logic                   done,         // one cycle at the end
   output logic                   fail          // sticky mismatch
);

   import sync_fifo_pkg::*;

   localparam int    lat       = REG + 1;                       // read latency in edges
   localparam addr_t last_addr = addr_t'(`FIFO_DEPTH - 1);
   localparam data_t pat_seed  = data_t'(64'hA5C3_96E1_5A3C_691E);

   bist_state_t      state;
   addr_t            addr;                 // walks every word each pass
   data_t            pat;                  // pattern A for this address
   data_t            expected;             // word a read should return
   logic             inv_pass;             // inverse passes
   logic [lat-1:0]   pipe_vld;             // reads in flight per stage
   data_t            pipe_exp [lat];       // expected words riding along

   //############################################################
   // sequencer
   //############################################################
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         state <= idle;
         addr  <= '0;
      end
      else
      begin
         case (state)
            idle:
               if (start)
               begin
                  state <= write_pat;
                  addr  <= '0;
               end
            write_pat, read_pat, write_inv, read_inv:
            begin
               addr <= (addr == last_addr) ? '0 : addr + 1'b1;
               if (addr == last_addr)
               begin
                  case (state)
                     write_pat: state <= read_pat;
                     read_pat:  state <= write_inv;
                     write_inv: state <= read_inv;
                     default:   state <= drain;
                  endcase
               end
            end
            drain:
               if (~|pipe_vld)       // last compare done
                  state <= finish;
            default:
               state <= idle;        // finish
         endcase
      end
   end

   assign bist_en = (state != idle);                      // held through the done cycle
   assign busy    = (state != idle) && (state != finish);
   assign done    = (state == finish);

   //############################################################
   // test port requests
   //############################################################
   assign inv_pass = (state == write_inv) || (state == read_inv);
   assign pat      = data_t'(addr) ^ pat_seed;            // address dependent word
   assign expected = inv_pass ? ~pat : pat;

   always_comb
   begin
      bist_wr.en   = (state == write_pat) || (state == write_inv);
      bist_wr.addr = addr;
      bist_wr.data = expected;
      bist_rd.en   = (state == read_pat) || (state == read_inv);
      bist_rd.addr = addr;
   end

   //############################################################
   // compare pipe
   //############################################################
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         pipe_vld <= '0;
      else
      begin
         pipe_vld[0] <= bist_rd.en;
         for (int i = 1; i < lat; i++)
            pipe_vld[i] <= pipe_vld[i-1];
      end
   end

   always_ff @(posedge clk)
   begin
      pipe_exp[0] <= expected;
      for (int i = 1; i < lat; i++)
         pipe_exp[i] <= pipe_exp[i-1];
   end

   // word at the pipe end lines up with rd_data
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         fail <= 1'b0;
      else if ((state == idle) && start)
         fail <= 1'b0;                                    // fresh run
      else if (pipe_vld[lat-1] && (rd_data != pipe_exp[lat-1]))
         fail <= 1'b1;
   end

endmodule

// ==== verilog/fifo_subsys_top.sv ====
// FIFO subsystem top joining the FIFO controller and the memory self-test engine
`timescale 1ns/1ps
`include "sync_fifo_defs.svh"

module fifo_subsys_top (
   input  logic                  clk,          // clock
   input  logic                  nreset,       // async reset, active low
   input  logic                  clear,        // sync clear
   input  logic                  write,        // write strobe
   input  sync_fifo_pkg::data_t  din,          // write word
   output logic                  full,         // no room
   output logic                  progfull,     // almost full
   input  logic                  read,         // read strobe
   output sync_fifo_pkg::data_t  dout,         // read word
   output logic                  empty,        // nothing to read
   output sync_fifo_pkg::count_t count,        // stored words
   input  logic                  bist_start,   // self-test start pulse
   output logic                  bist_busy,    // self-test running
   output logic                  bist_done,    // self-test end pulse
   output logic                  bist_fail     // self-test mismatch seen
);

   import sync_fifo_pkg::*;

   logic    bist_en;     // memory handed to the test engine
   mem_wr_s bist_wr;
   mem_rd_s bist_rd;
   data_t   mem_data;    // raw read data back to the engine

   //############################################################
   // FIFO controller and memory
   //############################################################
   fifo_sync #(
      .REG       (`FIFO_REG),
      .PROGFULL  (`FIFO_PROGFULL)
   ) fifo0 (
      .clk       (clk),
      .nreset    (nreset),
      .clear     (clear),
      .write     (write),
      .din       (din),
      .read      (read),
      .bist_en   (bist_en),
      .bist_done (bist_done),   // clears pointers as the test ends
      .bist_wr   (bist_wr),
      .bist_rd   (bist_rd),
      .dout      (dout),
      .full      (full),
      .empty     (empty),
      .count     (count),
      .progfull  (progfull),
      .mem_data  (mem_data)
   );

   //############################################################
   // self-test engine
   //############################################################
   mem_bist #(
      .REG     (`FIFO_REG)    // compare latency follows the memory
   ) bist0 (
      .clk     (clk),
      .nreset  (nreset),
      .start   (bist_start),
      .rd_data (mem_data),
      .bist_en (bist_en),
      .bist_wr (bist_wr),
      .bist_rd (bist_rd),
      .busy    (bist_busy),
      .done    (bist_done),
      .fail    (bist_fail)
   );

endmodule

// ==== dv/tb_fifo_subsys.sv ====
// directed testbench for the FIFO subsystem, checked against a queue reference model
`timescale 1ns/1ps
`include "sync_fifo_defs.svh"

module tb_fifo_subsys;

   import sync_fifo_pkg::*;

   logic   clk;
   logic   nreset;
   logic   clear;
   logic   write;
   data_t  din;
   logic   read;
   logic   bist_start;
   logic   full;
   logic   progfull;
   data_t  dout;
   logic   empty;
   count_t count;
   logic   bist_busy;
   logic   bist_done;
   logic   bist_fail;

   data_t  model_q [$];     // words the FIFO should hold
   logic   exp_empty;       // empty as the flag should show it
   logic   exp_vld [3];     // reads on their way to dout
   data_t  exp_dat [3];
   int     both_seen;       // cycles with read and write both accepted
   int     fail_count;
   string  cur_test;

   fifo_subsys_top dut0 (
      .clk        (clk),
      .nreset     (nreset),
      .clear      (clear),
      .write      (write),
      .din        (din),
      .full       (full),
      .progfull   (progfull),
      .read       (read),
      .dout       (dout),
      .empty      (empty),
      .count      (count),
      .bist_start (bist_start),
      .bist_busy  (bist_busy),
      .bist_done  (bist_done),
      .bist_fail  (bist_fail)
   );

   initial
   begin
      clk = 1'b0;
      forever #2 clk = ~clk;   // 4 ns period
   end

   //############################################################
   // checking
   //############################################################
   task automatic check(input string sig, input data_t exp_val, input data_t act_val);
      if (act_val !== exp_val)
      begin
         fail_count++;
         $display("MISMATCH test=%s signal=%s expected=%h actual=%h",
                  cur_test, sig, exp_val, act_val);
         $display("Simulation failed");
         $fatal(1, "stopped at first mismatch");
      end
   endtask

   task automatic report_timeout(input string what);
      $display("timeout in %s: %s", cur_test, what);
      $display("Simulation failed");
      $fatal(1, "wait ran out of cycles");
   endtask

   // flags and count straight from the model, dout only when a word is due
   task automatic check_outputs();
      check("count", data_t'(model_q.size()), data_t'(count));
      check("full", model_q.size() == `FIFO_DEPTH, full);
      check("progfull", model_q.size() >= `FIFO_PROGFULL, progfull);
      check("empty", exp_empty, empty);
      check("bist_busy", 1'b0, bist_busy);
      check("bist_done", 1'b0, bist_done);
      check("bist_fail", 1'b0, bist_fail);
      if (exp_vld[0])
         check("dout", exp_dat[0], dout);
   endtask

   function automatic void resync_model();
      model_q.delete();
      exp_empty = 1'b1;
      for (int i = 0; i < 3; i++)
         exp_vld[i] = 1'b0;
   endfunction

   //############################################################
   // one clock of stimulus plus model update
   //############################################################
   task automatic cycle(input logic wr, input logic rd, input logic clr, input data_t d);
      int    size_before;
      logic  wok;
      logic  rok;
      data_t word;
      @(posedge clk);
      write <= wr;
      read  <= rd;
      clear <= clr;
      din   <= d;
      @(negedge clk);
      check_outputs();
      // what the next edge does with these inputs
      size_before = model_q.size();
      wok = wr && !clr && (size_before < `FIFO_DEPTH);
      rok = rd && !clr && !exp_empty && (size_before > 0);
      exp_vld[0] = exp_vld[1];
      exp_dat[0] = exp_dat[1];
      exp_vld[1] = exp_vld[2];
      exp_dat[1] = exp_dat[2];
      exp_vld[2] = 1'b0;
      if (clr)
         model_q.delete();   // clear beats write and read
      else
      begin
         if (rok)
         begin
            word = model_q.pop_front();
            exp_vld[`FIFO_REG] = 1'b1;   // one more edge with the output register
            exp_dat[`FIFO_REG] = word;
         end
         if (wok)
            model_q.push_back(d);
         if (wok && rok)
            both_seen++;
      end
      // registered empty follows the level before the edge
      exp_empty = (`FIFO_REG != 0) ? (size_before == 0) : (model_q.size() == 0);
   endtask

   task automatic wait_empty();
      int waited;
      waited = 0;
      while (empty !== 1'b1)
      begin
         if (waited >= 8)
            report_timeout("empty did not rise");
         else
         begin
            cycle(1'b0, 1'b0, 1'b0, '0);
            waited++;
         end
      end
   endtask

   //############################################################
   // tests
   //############################################################
   task automatic reset_values();
      cur_test = "reset_state";
      @(negedge clk);
      check_outputs();
   endtask

   task automatic fill_to_full();
      cur_test = "fill_to_full";
      for (int i = 0; i < `FIFO_DEPTH; i++)
         cycle(1'b1, 1'b0, 1'b0, data_t'($urandom));
      cycle(1'b1, 1'b0, 1'b0, data_t'($urandom));   // no room, dropped
      cycle(1'b0, 1'b0, 1'b0, '0);
      check("count", `FIFO_DEPTH, count);
      check("full", 1'b1, full);
   endtask

   task automatic drain_in_order();
      data_t last_word;
      cur_test = "drain_in_order";
      last_word = model_q[$];   // final word out, stays on dout
      for (int i = 0; i < `FIFO_DEPTH; i++)
         cycle(1'b0, 1'b1, 1'b0, '0);
      wait_empty();
      cycle(1'b0, 1'b1, 1'b0, '0);   // read on empty, ignored
      repeat (3) cycle(1'b0, 1'b0, 1'b0, '0);
      check("count", 0, count);
      check("dout", last_word, dout);   // no read, no new word
   endtask

   task automatic mixed_traffic();
      cur_test = "mixed_stream";
      both_seen = 0;
      repeat (400)
         cycle(($urandom % 2) == 1, ($urandom % 2) == 1, 1'b0, data_t'($urandom));
      for (int i = 0; i < `FIFO_DEPTH + 2; i++)
         cycle(1'b0, 1'b1, 1'b0, '0);
      wait_empty();
      check("both_accepted_seen", 1'b1, both_seen > 0);
   endtask

   task automatic clear_restart();
      cur_test = "clear";
      repeat (6) cycle(1'b1, 1'b0, 1'b0, data_t'($urandom));
      cycle(1'b1, 1'b1, 1'b1, data_t'($urandom));   // clear wins over both strobes
      wait_empty();
      check("count", 0, count);
      // fresh start after the clear
      repeat (3) cycle(1'b1, 1'b0, 1'b0, data_t'($urandom));
      repeat (5) cycle(1'b0, 1'b1, 1'b0, '0);
      wait_empty();
      check("count", 0, count);
   endtask

   task automatic run_self_test();
      int waited;
      cur_test = "self_test";
      repeat (5) cycle(1'b1, 1'b0, 1'b0, data_t'($urandom));
      repeat (3) cycle(1'b0, 1'b0, 1'b0, '0);   // let dout settle
      @(posedge clk);
      bist_start <= 1'b1;
      @(posedge clk);
      bist_start <= 1'b0;
      @(negedge clk);
      waited = 0;
      while (bist_done !== 1'b1)
      begin
         check("bist_busy", 1'b1, bist_busy);
         check("full", 1'b1, full);      // test port owns the memory
         if (waited >= 200)
            report_timeout("self-test done never came");
         else
         begin
            @(negedge clk);
            waited++;
         end
      end
      // four passes over every word, one access per cycle
      check("self_test_cycles", 1'b1, waited >= 4 * `FIFO_DEPTH);
      check("bist_busy", 1'b0, bist_busy);
      check("bist_fail", 1'b0, bist_fail);
      resync_model();   // contents dropped as the test ends
      repeat (4) cycle(1'b1, 1'b0, 1'b0, data_t'($urandom));
      repeat (6) cycle(1'b0, 1'b1, 1'b0, '0);
      wait_empty();
      check("count", 0, count);
   endtask

   //############################################################
   // main sequence
   //############################################################
   initial
   begin
      void'($urandom(95));
      fail_count = 0;
      both_seen  = 0;
      cur_test   = "init";
      resync_model();
      nreset     <= 1'b0;
      clear      <= 1'b0;
      write      <= 1'b0;
      read       <= 1'b0;
      din        <= '0;
      bist_start <= 1'b0;
      repeat (4) @(posedge clk);
      nreset <= 1'b1;
      reset_values();
      fill_to_full();
      drain_in_order();
      mixed_traffic();
      clear_restart();
      run_self_test();
      repeat (2) cycle(1'b0, 1'b0, 1'b0, '0);
      if (fail_count == 0)
      begin
         $display("Simulation passed");
         $finish;
      end
      else
      begin
         $display("Simulation failed");
         $fatal(1, "checks failed");
      end
   end

endmodule

// ==== sync_fifo.f ====
+incdir+verilog
verilog/sync_fifo_pkg.sv
verilog/mem_dual_port.sv
verilog/fifo_sync.sv
verilog/mem_bist.sv
verilog/fifo_subsys_top.sv
dv/tb_fifo_subsys.sv

// ==== Bender.yml ====
package:
  name: sync_fifo

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/sync_fifo_pkg.sv
      - verilog/mem_dual_port.sv
      - verilog/fifo_sync.sv
      - verilog/mem_bist.sv
      - verilog/fifo_subsys_top.sv
  - target: simulation
    include_dirs:
      - verilog
    files:
      - dv/tb_fifo_subsys.sv
